// File: list.f
verilog/mem_layout_pkg.sv
verilog/mem_view_pkg.sv
verilog/bank_ram.sv
verilog/bank_array.sv
verilog/view_addr_map.sv
verilog/read_port.sv
verilog/write_port.sv
verilog/main_mem.sv
verification/tb_clock.sv
verification/main_mem_sva.sv
verification/main_mem_tb.sv

// File: verification/main_mem_sva.sv
`timescale 1ns/1ps

module main_mem_sva (
  input logic                       clk,
  input logic                       i_rst,
  input mem_view_pkg::bank_req_t    i_rd_req,
  input mem_view_pkg::bank_req_t    i_wr_req,
  input mem_layout_pkg::line_data_t i_rd_data
);
  import mem_layout_pkg::*;

  int assert_fails = 0;

  ////////////////////////////////////////////////////////////
  // bank enables may be zero on idle cycles
  ////////////////////////////////////////////////////////////

  a_wr_bank_en: assert property (
    @(posedge clk) disable iff (i_rst)
      $onehot0(i_wr_req.bank_en) || (i_wr_req.bank_en == bank_en_t'('1))
  ) else begin
    $error("write bank enable is neither one-hot nor all ones");
    assert_fails++;
  end

  a_rd_bank_en: assert property (
    @(posedge clk) disable iff (i_rst)
      $onehot0(i_rd_req.bank_en) || (i_rd_req.bank_en == bank_en_t'('1))
  ) else begin
    $error("read bank enable is neither one-hot nor all ones");
    assert_fails++;
  end

  // masked data follows the two-stage read
  a_rd_idle_zero: assert property (
    @(posedge clk) disable iff (i_rst)
      (i_rd_req.bank_en == '0) |-> ##2 (i_rd_data == '0)
  ) else begin
    $error("read data not zero two cycles after a read with no enables");
    assert_fails++;
  end

endmodule

// File: verification/main_mem_tb.sv
`timescale 1ns/1ps

module main_mem_tb;
  import mem_layout_pkg::*;
  import mem_view_pkg::*;

  localparam int BANK_DEPTH     = 512;
  localparam int TIMEOUT_CYCLES = 5000;  // tests run in about 500 cycles

  typedef struct packed {
    line_t    line;
    bank_en_t bank_en;
  } ref_addr_t;

  typedef struct packed {
    view_index_t next;
    logic        has_next;
  } ref_walk_t;

  typedef struct packed {
    int         due;  // cycle at which data is on the outputs
    word_t      bus;
    line_data_t line;
  } rd_pending_t;

  logic        clk;
  logic        rst;
  mem_view_e   rd_view;
  view_index_t rd_index;
  view_index_t rd_index_next;
  logic        rd_has_next;
  word_t       rd_bus;
  line_data_t  rd_line;
  mem_view_e   wr_view;
  view_index_t wr_index;
  word_t       wr_bus;
  line_data_t  wr_line;
  view_index_t wr_index_next;
  logic        wr_has_next;

  word_t       ref_mem [NUM_BANKS][BANK_DEPTH];
  rd_pending_t pending[$];
  int          cyc = 0;
  int          err_count = 0;
  int          check_count = 0;
  int          test_count = 0;
  int          fail_count = 0;
  int          err_at_start = 0;
  string       test_name;

  tb_clock #(.PERIOD_NS(40)) u_clk (.clk(clk));

  main_mem #(
    .BANK_DEPTH(BANK_DEPTH)
  ) i_dut (
    .clk            (clk),
    .i_rst          (rst),
    .i_rd_view      (rd_view),
    .i_rd_index     (rd_index),
    .o_rd_index_next(rd_index_next),
    .o_rd_has_next  (rd_has_next),
    .o_rd_bus       (rd_bus),
    .o_rd_line      (rd_line),
    .i_wr_view      (wr_view),
    .i_wr_index     (wr_index),
    .i_wr_bus       (wr_bus),
    .i_wr_line      (wr_line),
    .o_wr_index_next(wr_index_next),
    .o_wr_has_next  (wr_has_next)
  );

  bind bank_array main_mem_sva u_sva (
    .clk      (clk),
    .i_rst    (i_rst),
    .i_rd_req (i_rd_req),
    .i_wr_req (i_wr_req),
    .i_rd_data(o_rd_line)
  );

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic line_t region_off(mem_view_e v);
    case (v)
      VIEW_SS_STATE:  return OFF_SS_STATE;
      VIEW_RNG_STATE: return OFF_RNG_STATE;
      VIEW_SALT:      return OFF_SALT;
      VIEW_SEED_SE:   return OFF_SEED_SE;
      VIEW_PKH:       return OFF_PKH;
      default:        return OFF_K;
    endcase
  endfunction

  function automatic int region_last(mem_view_e v);
    case (v)
      VIEW_SS_STATE:  return LAST_SS_STATE;
      VIEW_RNG_STATE: return LAST_RNG_STATE;
      VIEW_SALT:      return LAST_SALT;
      VIEW_SEED_SE:   return LAST_SEED_SE;
      VIEW_PKH:       return LAST_PKH;
      default:        return LAST_K;
    endcase
  endfunction

  function automatic ref_addr_t ref_addr(mem_view_e v, view_index_t idx);
    ref_addr_t a;
    a = '0;
    if (v == VIEW_B_ROW) begin
      a.line    = idx[8:0];
      a.bank_en = bank_en_t'(1) << idx[11:9];
    end else if (v == VIEW_B_MAT) begin
      a.line    = idx[8:0];
      a.bank_en = '1;
    end else if (v != VIEW_NONE) begin
      a.line    = region_off(v) + line_t'(idx / 8);  // eight words per line
      a.bank_en = bank_en_t'(1) << idx[2:0];
    end
    return a;
  endfunction

  function automatic ref_walk_t ref_walk(mem_view_e v, view_index_t idx);
    ref_walk_t w;
    w.next     = idx + 1'b1;
    w.has_next = 1'b0;
    if (v == VIEW_B_ROW) begin
      if (idx[8:0] == 9'(B_LINES - 1))
        w.next = {idx[13:9] + 5'd1, 9'd0};  // wrap to next bank
      w.has_next = !(idx[13:9] == 5'd7 && idx[8:0] == 9'(B_LINES - 1));
    end else if (v == VIEW_B_MAT) begin
      w.has_next = (idx != view_index_t'(B_LINES - 1));
    end else if (v != VIEW_NONE) begin
      w.has_next = (idx != view_index_t'(region_last(v)));
    end
    return w;
  endfunction

  function automatic rd_pending_t ref_read(mem_view_e v, view_index_t idx);
    ref_addr_t   a;
    rd_pending_t p;
    a = ref_addr(v, idx);
    p = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (a.bank_en[b]) begin
        p.line[b] = ref_mem[b][a.line];
        p.bus     = p.bus | ref_mem[b][a.line];
      end
    end
    return p;
  endfunction

  function automatic void ref_write(mem_view_e v, view_index_t idx, word_t bus, line_data_t line);
    ref_addr_t a;
    a = ref_addr(v, idx);
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (a.bank_en[b])
        ref_mem[b][a.line] = (v == VIEW_B_MAT) ? line[b] : bus;
    end
  endfunction

  function automatic word_t rand_word();
    return {$urandom, $urandom};
  endfunction

  function automatic line_data_t rand_line();
    line_data_t l;
    for (int b = 0; b < NUM_BANKS; b++)
      l[b] = rand_word();
    return l;
  endfunction

  ////////////////////////////////////////////////////////////
  // checks and stimulus
  ////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input word_t got, input word_t exp);
    check_count++;
    assert (got === exp) else begin
      $display("[ERROR] %s: got %0h, expected %0h (%s)", name, got, exp, test_name);
      err_count++;
    end
  endtask

  task automatic check_line(input string name, input line_data_t got, input line_data_t exp);
    check_count++;
    assert (got === exp) else begin
      $display("[ERROR] %s: got %h, expected %h (%s)", name, got, exp, test_name);
      err_count++;
    end
  endtask

  task automatic check_cond(input bit ok, input string msg);
    check_count++;
    assert (ok) else begin
      $display("%s (%s)", msg, test_name);
      err_count++;
    end
  endtask

  // drives one cycle on both ports from 1 ns after a rising edge
  task automatic drive_cycle(
    input  mem_view_e   rv,
    input  view_index_t ri,
    input  mem_view_e   wv,
    input  view_index_t wi,
    input  word_t       wb,
    input  line_data_t  wl,
    output view_index_t nx,
    output logic        hn
  );
    rd_pending_t p;
    ref_walk_t   rw;
    ref_walk_t   ww;
    rd_view  = rv;
    rd_index = ri;
    wr_view  = wv;
    wr_index = wi;
    wr_bus   = wb;
    wr_line  = wl;
    if (rv != VIEW_NONE) begin
      p     = ref_read(rv, ri);  // model still holds the old data here
      p.due = cyc + 2;
      pending.push_back(p);
    end
    ref_write(wv, wi, wb, wl);
    rw = ref_walk(rv, ri);
    ww = ref_walk(wv, wi);
    #1;
    check_word("o_rd_has_next", rd_has_next, rw.has_next);
    check_word("o_wr_has_next", wr_has_next, ww.has_next);
    if (rv != VIEW_NONE)
      check_word("o_rd_index_next", rd_index_next, rw.next);
    if (wv != VIEW_NONE)
      check_word("o_wr_index_next", wr_index_next, ww.next);
    nx = wr_index_next;
    hn = wr_has_next;
    @(posedge clk);
    #1;
  endtask

  task automatic read_at(input mem_view_e v, input view_index_t idx);
    view_index_t nx;
    logic        hn;
    drive_cycle(v, idx, VIEW_NONE, '0, '0, '0, nx, hn);
  endtask

  task automatic start_test(input string name);
    test_name    = name;
    err_at_start = err_count;
  endtask

  task automatic finish_test();
    view_index_t nx;
    logic        hn;
    while (pending.size() > 0)
      drive_cycle(VIEW_NONE, '0, VIEW_NONE, '0, '0, '0, nx, hn);
    test_count++;
    if (err_count != err_at_start)
      fail_count++;
    $display("test %-13s %0d errors", test_name, err_count - err_at_start);
  endtask

  // compare read data in mid cycle
  always @(negedge clk) begin
    if (pending.size() > 0 && pending[0].due == cyc) begin
      check_word("o_rd_bus", rd_bus, pending[0].bus);
      check_line("o_rd_line", rd_line, pending[0].line);
      pending.delete(0);
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, tests did not finish", cyc);
      $display("Test failures found");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  initial begin
    view_index_t idx;
    view_index_t nx;
    logic        hn;
    int          steps;
    int          sva_fails;
    mem_view_e   v;
    line_t       lines[$];
    view_index_t written[$];
    mem_view_e   cells[6];
    void'($urandom(32'h9289));
    cells    = '{VIEW_SS_STATE, VIEW_RNG_STATE, VIEW_SALT, VIEW_SEED_SE, VIEW_PKH, VIEW_K};
    rst      = 1'b1;
    rd_view  = VIEW_NONE;
    rd_index = '0;
    wr_view  = VIEW_NONE;
    wr_index = '0;
    wr_bus   = '0;
    wr_line  = '0;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    start_test("reset");
    check_word("o_rd_bus", rd_bus, '0);
    check_line("o_rd_line", rd_line, '0);
    check_word("o_rd_has_next", rd_has_next, '0);
    check_word("o_wr_has_next", wr_has_next, '0);
    finish_test();

    start_test("cell regions");
    foreach (cells[c]) begin
      idx   = '0;
      hn    = 1'b1;
      steps = 0;
      while (hn === 1'b1 && steps < 64) begin
        drive_cycle(VIEW_NONE, '0, cells[c], idx, rand_word(), '0, nx, hn);
        steps++;
        idx = nx;
      end
      check_cond(steps == region_last(cells[c]) + 1,
                 $sformatf("%s walk took %0d steps", cells[c].name(), steps));
      for (int i = 0; i < steps; i++)
        read_at(cells[c], view_index_t'(i));
    end
    finish_test();

    start_test("b row wrap");
    for (int b = 0; b < NUM_BANKS; b++) begin
      idx = {5'(b), 9'd333};
      for (int s = 0; s < 4; s++) begin
        written.push_back(idx);
        drive_cycle(VIEW_NONE, '0, VIEW_B_ROW, idx, rand_word(), '0, nx, hn);
        if (hn !== 1'b1)
          break;
        idx = nx;
      end
    end
    check_cond(hn === 1'b0 && written[$] == {5'd7, 9'd335},
               "B row walk did not end at bank 7 line 335");
    foreach (written[i])
      read_at(VIEW_B_ROW, written[i]);
    finish_test();

    start_test("cross view");
    repeat (16) lines.push_back(line_t'($urandom_range(B_LINES - 1)));
    foreach (lines[i])
      drive_cycle(VIEW_NONE, '0, VIEW_B_MAT, view_index_t'(lines[i]), '0, rand_line(), nx, hn);
    foreach (lines[i])
      read_at(VIEW_B_MAT, view_index_t'(lines[i]));
    foreach (lines[i]) begin
      for (int b = 0; b < NUM_BANKS; b++)
        read_at(VIEW_B_ROW, {5'(b), lines[i]});
    end
    foreach (lines[i]) begin
      idx = {5'($urandom_range(NUM_BANKS - 1)), lines[i]};  // one bank word only
      drive_cycle(VIEW_NONE, '0, VIEW_B_ROW, idx, rand_word(), '0, nx, hn);
      read_at(VIEW_B_MAT, view_index_t'(lines[i]));
    end
    finish_test();

    start_test("same edge");
    for (int r = 0; r < 6; r++) begin
      if (r % 2 == 0) begin
        v   = VIEW_B_ROW;
        idx = {5'($urandom_range(NUM_BANKS - 1)), 9'($urandom_range(B_LINES - 1))};
      end else begin
        v   = VIEW_B_MAT;
        idx = view_index_t'($urandom_range(B_LINES - 1));
      end
      drive_cycle(VIEW_NONE, '0, v, idx, rand_word(), rand_line(), nx, hn);
      drive_cycle(v, idx, v, idx, rand_word(), rand_line(), nx, hn);
      read_at(v, idx);
    end
    finish_test();

    sva_fails = i_dut.u_bank_array.u_sva.assert_fails;
    $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
             test_count, fail_count, check_count, err_count, sva_fails);
    if (err_count == 0 && sva_fails == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: verification/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk = ~clk;  // half period
    end
  end

endmodule

// File: verilog/bank_array.sv
`timescale 1ns/1ps

module bank_array #(
  parameter int BANK_DEPTH = 512
) (
  input  logic                       clk,
  input  logic                       i_rst,
  input  mem_view_pkg::bank_req_t    i_rd_req,
  output mem_layout_pkg::line_data_t o_rd_line,
  input  mem_view_pkg::bank_req_t    i_wr_req,
  input  mem_layout_pkg::line_data_t i_wr_line
);
  import mem_layout_pkg::*;

  bank_en_t   rd_bank_en_d1;
  bank_en_t   rd_bank_en_d2;
  byte_en_t   rd_byte_en_d1;
  byte_en_t   rd_byte_en_d2;
  line_data_t rd_raw;

  ////////////////////////////////////////////////////////////
  // enables follow the RAM read pipeline
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (i_rst) begin
      rd_bank_en_d1 <= '0;
      rd_bank_en_d2 <= '0;
      rd_byte_en_d1 <= '0;
      rd_byte_en_d2 <= '0;
    end else begin
      rd_bank_en_d1 <= i_rd_req.bank_en;
      rd_bank_en_d2 <= rd_bank_en_d1;
      rd_byte_en_d1 <= i_rd_req.byte_en;
      rd_byte_en_d2 <= rd_byte_en_d1;
    end
  end

  ////////////////////////////////////////////////////////////
  // banks and read masking
  ////////////////////////////////////////////////////////////

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    bank_ram #(
      .BANK_DEPTH(BANK_DEPTH)
    ) u_ram (
      .clk         (clk),
      .i_rd_en     (i_rd_req.bank_en[b]),
      .i_rd_line   (i_rd_req.line),
      .o_rd_word   (rd_raw[b]),
      .i_wr_en     (i_wr_req.bank_en[b]),
      .i_wr_byte_en(i_wr_req.byte_en),
      .i_wr_line   (i_wr_req.line),
      .i_wr_word   (i_wr_line[b])
    );

    for (genvar y = 0; y < BYTES_PER_WORD; y++) begin : g_byte
      assign o_rd_line[b][y*8 +: 8] =
        rd_raw[b][y*8 +: 8] & {8{rd_bank_en_d2[b] & rd_byte_en_d2[y]}};
    end
  end

endmodule

// File: verilog/bank_ram.sv
`timescale 1ns/1ps

module bank_ram #(
  parameter int BANK_DEPTH = 512
) (
  input  logic                     clk,
  input  logic                     i_rd_en,
  input  mem_layout_pkg::line_t    i_rd_line,
  output mem_layout_pkg::word_t    o_rd_word,
  input  logic                     i_wr_en,
  input  mem_layout_pkg::byte_en_t i_wr_byte_en,
  input  mem_layout_pkg::line_t    i_wr_line,
  input  mem_layout_pkg::word_t    i_wr_word
);
  import mem_layout_pkg::*;

  word_t mem [BANK_DEPTH];
  word_t rd_data_q;  // array read stage
  word_t rd_out_q;   // output register stage

  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      for (int b = 0; b < BYTES_PER_WORD; b++) begin
        if (i_wr_byte_en[b]) begin
          mem[i_wr_line][b*8 +: 8] <= i_wr_word[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_rd_en) begin
      rd_data_q <= mem[i_rd_line];  // old data on same-edge write
    end
    rd_out_q <= rd_data_q;
  end

  assign o_rd_word = rd_out_q;

endmodule

// File: verilog/main_mem.sv
`timescale 1ns/1ps

module main_mem #(
  parameter int BANK_DEPTH = 512
) (
  input  logic                       clk,
  input  logic                       i_rst,

  input  mem_view_pkg::mem_view_e    i_rd_view,
  input  mem_view_pkg::view_index_t  i_rd_index,
  output mem_view_pkg::view_index_t  o_rd_index_next,
  output logic                       o_rd_has_next,
  output mem_layout_pkg::word_t      o_rd_bus,    // two cycles after request
  output mem_layout_pkg::line_data_t o_rd_line,   // two cycles after request

  input  mem_view_pkg::mem_view_e    i_wr_view,
  input  mem_view_pkg::view_index_t  i_wr_index,
  input  mem_layout_pkg::word_t      i_wr_bus,
  input  mem_layout_pkg::line_data_t i_wr_line,
  output mem_view_pkg::view_index_t  o_wr_index_next,
  output logic                       o_wr_has_next
);
  import mem_layout_pkg::*;
  import mem_view_pkg::*;

  bank_req_t  rd_req;
  bank_req_t  wr_req;
  line_data_t rd_line;
  line_data_t wr_line;

  read_port u_read_port (
    .i_view      (i_rd_view),
    .i_index     (i_rd_index),
    .o_index_next(o_rd_index_next),
    .o_has_next  (o_rd_has_next),
    .o_req       (rd_req),
    .i_line      (rd_line),
    .o_bus       (o_rd_bus),
    .o_line      (o_rd_line)
  );

  write_port u_write_port (
    .i_view      (i_wr_view),
    .i_index     (i_wr_index),
    .i_bus       (i_wr_bus),
    .i_line      (i_wr_line),
    .o_index_next(o_wr_index_next),
    .o_has_next  (o_wr_has_next),
    .o_req       (wr_req),
    .o_line      (wr_line)
  );

  bank_array #(
    .BANK_DEPTH(BANK_DEPTH)
  ) u_bank_array (
    .clk      (clk),
    .i_rst    (i_rst),
    .i_rd_req (rd_req),
    .o_rd_line(rd_line),
    .i_wr_req (wr_req),
    .i_wr_line(wr_line)
  );

endmodule

// File: verilog/mem_layout_pkg.sv
package mem_layout_pkg;

  ////////////////////////////////////////////////////////////
  // bank geometry
  ////////////////////////////////////////////////////////////

  localparam int NUM_BANKS      = 8;
  localparam int WORD_W         = 64;
  localparam int BYTES_PER_WORD = WORD_W / 8;
  localparam int LINE_W         = 9;  // 512 lines per bank

  typedef logic [LINE_W-1:0]         line_t;
  typedef logic [WORD_W-1:0]         word_t;
  typedef word_t [NUM_BANKS-1:0]     line_data_t;  // bank 0 lowest
  typedef logic [BYTES_PER_WORD-1:0] byte_en_t;
  typedef logic [NUM_BANKS-1:0]      bank_en_t;

  ////////////////////////////////////////////////////////////
  // region map, holes left where S, C and U used to sit
  ////////////////////////////////////////////////////////////

  localparam line_t OFF_B         = 9'd0;
  localparam line_t OFF_SS_STATE  = 9'd420;
  localparam line_t OFF_RNG_STATE = 9'd426;
  localparam line_t OFF_SALT      = 9'd427;
  localparam line_t OFF_SEED_SE   = 9'd428;
  localparam line_t OFF_PKH       = 9'd429;
  localparam line_t OFF_K         = 9'd431;

  localparam int B_LINES = 336;  // lines per bank used by B

  // last valid index of each cell region
  localparam int LAST_SS_STATE  = 24;
  localparam int LAST_RNG_STATE = 7;
  localparam int LAST_SALT      = 7;
  localparam int LAST_SEED_SE   = 7;
  localparam int LAST_PKH       = 3;
  localparam int LAST_K         = 3;

endpackage

// File: verilog/mem_view_pkg.sv
package mem_view_pkg;

  ////////////////////////////////////////////////////////////
  // logical views of the memory
  ////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    VIEW_NONE,
    VIEW_B_ROW,      // 16b1x4, one bank word per step
    VIEW_B_MAT,      // 16b8x4, full line per step
    VIEW_SS_STATE,
    VIEW_RNG_STATE,
    VIEW_SALT,
    VIEW_SEED_SE,
    VIEW_PKH,
    VIEW_K
  } mem_view_e;

  localparam int INDEX_W = 14;

  // B row packs {bank[4:0], line[8:0]}, other views count up
  typedef logic [INDEX_W-1:0] view_index_t;

  ////////////////////////////////////////////////////////////
  // request presented to the bank array
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    mem_layout_pkg::line_t    line;
    mem_layout_pkg::bank_en_t bank_en;
    mem_layout_pkg::byte_en_t byte_en;
  } bank_req_t;

endpackage

// File: verilog/read_port.sv
`timescale 1ns/1ps

module read_port (
  input  mem_view_pkg::mem_view_e    i_view,
  input  mem_view_pkg::view_index_t  i_index,
  output mem_view_pkg::view_index_t  o_index_next,
  output logic                       o_has_next,
  output mem_view_pkg::bank_req_t    o_req,
  input  mem_layout_pkg::line_data_t i_line,
  output mem_layout_pkg::word_t      o_bus,
  output mem_layout_pkg::line_data_t o_line
);
  import mem_layout_pkg::*;

  view_addr_map u_map (
    .i_view      (i_view),
    .i_index     (i_index),
    .o_req       (o_req),
    .o_index_next(o_index_next),
    .o_has_next  (o_has_next)
  );

  ////////////////////////////////////////////////////////////
  // merge of masked bank words
  ////////////////////////////////////////////////////////////

  // disabled banks are already zero, so OR picks the live word
  always_comb begin
    o_bus = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      o_bus = o_bus | i_line[b];
    end
  end

  assign o_line = i_line;  // B matrix view

endmodule

// File: verilog/view_addr_map.sv
`timescale 1ns/1ps

module view_addr_map (
  input  mem_view_pkg::mem_view_e   i_view,
  input  mem_view_pkg::view_index_t i_index,
  output mem_view_pkg::bank_req_t   o_req,
  output mem_view_pkg::view_index_t o_index_next,
  output logic                      o_has_next
);
  import mem_layout_pkg::*;
  import mem_view_pkg::*;

  // bank 7, line 335
  localparam view_index_t B_ROW_LAST =
    view_index_t'((NUM_BANKS - 1) * (2 ** LINE_W) + B_LINES - 1);
  localparam view_index_t B_MAT_LAST = view_index_t'(B_LINES - 1);

  logic        is_cell;
  line_t       cell_off;
  view_index_t cell_last;

  ////////////////////////////////////////////////////////////
  // cell region lookup
  ////////////////////////////////////////////////////////////

  always_comb begin
    is_cell   = 1'b1;
    cell_off  = '0;
    cell_last = '0;
    case (i_view)
      VIEW_SS_STATE: begin
        cell_off  = OFF_SS_STATE;
        cell_last = view_index_t'(LAST_SS_STATE);
      end
      VIEW_RNG_STATE: begin
        cell_off  = OFF_RNG_STATE;
        cell_last = view_index_t'(LAST_RNG_STATE);
      end
      VIEW_SALT: begin
        cell_off  = OFF_SALT;
        cell_last = view_index_t'(LAST_SALT);
      end
      VIEW_SEED_SE: begin
        cell_off  = OFF_SEED_SE;
        cell_last = view_index_t'(LAST_SEED_SE);
      end
      VIEW_PKH: begin
        cell_off  = OFF_PKH;
        cell_last = view_index_t'(LAST_PKH);
      end
      VIEW_K: begin
        cell_off  = OFF_K;
        cell_last = view_index_t'(LAST_K);
      end
      default: is_cell = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // address, enables and index walk
  ////////////////////////////////////////////////////////////

  always_comb begin
    o_req        = '0;
    o_index_next = i_index + 1'b1;
    o_has_next   = 1'b0;
    case (i_view)
      VIEW_B_ROW: begin
        o_req.line    = OFF_B + i_index[LINE_W-1:0];
        o_req.bank_en = bank_en_t'(1) << i_index[LINE_W+2:LINE_W];
        o_req.byte_en = '1;
        if (i_index[LINE_W-1:0] == line_t'(B_LINES - 1)) begin
          o_index_next = {i_index[INDEX_W-1:LINE_W] + 5'd1, {LINE_W{1'b0}}};  // next bank
        end
        o_has_next = (i_index != B_ROW_LAST);
      end
      VIEW_B_MAT: begin
        o_req.line    = OFF_B + i_index[LINE_W-1:0];
        o_req.bank_en = '1;
        o_req.byte_en = '1;
        o_has_next    = (i_index != B_MAT_LAST);
      end
      default: begin
        if (is_cell) begin
          o_req.line    = cell_off + line_t'(i_index / NUM_BANKS);
          o_req.bank_en = bank_en_t'(1) << (i_index % NUM_BANKS);  // words spread over banks
          o_req.byte_en = '1;
          o_has_next    = (i_index != cell_last);
        end
      end
    endcase
  end

endmodule

// File: verilog/write_port.sv
`timescale 1ns/1ps

module write_port (
  input  mem_view_pkg::mem_view_e    i_view,
  input  mem_view_pkg::view_index_t  i_index,
  input  mem_layout_pkg::word_t      i_bus,
  input  mem_layout_pkg::line_data_t i_line,
  output mem_view_pkg::view_index_t  o_index_next,
  output logic                       o_has_next,
  output mem_view_pkg::bank_req_t    o_req,
  output mem_layout_pkg::line_data_t o_line
);
  import mem_layout_pkg::*;
  import mem_view_pkg::*;

  view_addr_map u_map (
    .i_view      (i_view),
    .i_index     (i_index),
    .o_req       (o_req),
    .o_index_next(o_index_next),
    .o_has_next  (o_has_next)
  );

  ////////////////////////////////////////////////////////////
  // bank write data
  ////////////////////////////////////////////////////////////

  // bus views copy the word everywhere, bank_en picks the target
  always_comb begin
    if (i_view == VIEW_B_MAT) begin
      o_line = i_line;
    end else begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        o_line[b] = i_bus;
      end
    end
  end

endmodule
